//--- hw/pkt_gen_pkg.sv
package pkt_gen_pkg;

    // ****************************************
    // stream and field widths
    // ****************************************
    localparam int DATA_WIDTH  = 32;
    localparam int PORT_NUM    = 16;
    localparam int DEST_W      = $clog2(PORT_NUM);
    localparam int PRIO_LEVELS = 8;
    localparam int PRIO_W      = $clog2(PRIO_LEVELS);
    localparam int LEN_W       = 8;      // length 1..255
    localparam int COUNT_W     = 16;

    // header word, right aligned
    localparam int HDR_LEN_LSB  = 0;
    localparam int HDR_PRIO_LSB = HDR_LEN_LSB + LEN_W;     // bits 10:8
    localparam int HDR_DEST_LSB = HDR_PRIO_LSB + PRIO_W;   // bits 14:11

    // ****************************************
    // register map
    // ****************************************
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;  // bit 0 start, reads 0
    localparam logic [AXI_ADDR_W-1:0] REG_DEST   = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_PRIO   = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_LEN    = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h10;  // bit 0 busy
    localparam logic [AXI_ADDR_W-1:0] REG_COUNT  = 8'h14;  // packets done, wraps

    function automatic logic [DATA_WIDTH-1:0] pack_header(input logic [DEST_W-1:0] dest,
                                                          input logic [PRIO_W-1:0] prio,
                                                          input logic [LEN_W-1:0]  len);
        logic [DATA_WIDTH-1:0] word;
        word = '0;
        word[HDR_LEN_LSB  +: LEN_W]  = len;
        word[HDR_PRIO_LSB +: PRIO_W] = prio;
        word[HDR_DEST_LSB +: DEST_W] = dest;
        return word;
    endfunction

endpackage

//--- hw/pkt_gen_regs.sv
`timescale 1ns/1ps

module pkt_gen_regs
    import pkt_gen_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // axi4-lite write
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,

    // axi4-lite read
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,

    // command to framer
    output logic                  cmd_start,
    output logic [DEST_W-1:0]     cmd_dest,
    output logic [PRIO_W-1:0]     cmd_prio,
    output logic [LEN_W-1:0]      cmd_len,
    input  logic                  pkt_done
);

    logic                  wr_en;
    logic                  rd_en;
    logic                  start_req;
    logic                  start_ok;
    logic                  busy;
    logic [DEST_W-1:0]     dest_q;
    logic [PRIO_W-1:0]     prio_q;
    logic [LEN_W-1:0]      len_q;
    logic [COUNT_W-1:0]    pkt_count;
    logic [AXI_DATA_W-1:0] rd_word;

    // ****************************************
    // write channel
    // ****************************************
    assign wr_en   = awvalid && wvalid && !bvalid;  // one write outstanding
    assign awready = wr_en;
    assign wready  = wr_en;
    assign bresp   = 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dest_q <= '0;
            prio_q <= '0;
            len_q  <= '0;
        end else if (wr_en) begin
            case (awaddr)
                REG_DEST: dest_q <= wdata[DEST_W-1:0];
                REG_PRIO: prio_q <= wdata[PRIO_W-1:0];
                REG_LEN:  len_q  <= wdata[LEN_W-1:0];
                default: ;                            // unmapped or read-only
            endcase
        end
    end

    // start only when idle and length is nonzero
    assign start_req = wr_en && (awaddr == REG_CTRL) && wdata[0];
    assign start_ok  = start_req && !busy && (len_q != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_start <= 1'b0;
            busy      <= 1'b0;
        end else begin
            cmd_start <= start_ok;
            if (start_ok) begin
                busy <= 1'b1;
            end else if (pkt_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (pkt_done) begin
            pkt_count <= pkt_count + 1'b1;       // wraps
        end
    end

    assign cmd_dest = dest_q;
    assign cmd_prio = prio_q;
    assign cmd_len  = len_q;

    // ****************************************
    // read channel
    // ****************************************
    assign rd_en   = arvalid && !rvalid;
    assign arready = rd_en;
    assign rresp   = 2'b00;

    always_comb begin
        rd_word = '0;
        case (araddr)
            REG_DEST:   rd_word[DEST_W-1:0]  = dest_q;
            REG_PRIO:   rd_word[PRIO_W-1:0]  = prio_q;
            REG_LEN:    rd_word[LEN_W-1:0]   = len_q;
            REG_STATUS: rd_word[0]           = busy;
            REG_COUNT:  rd_word[COUNT_W-1:0] = pkt_count;
            default:    rd_word = '0;           // ctrl and unmapped
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
            rdata  <= rd_word;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

//--- hw/pkt_framer.sv
`timescale 1ns/1ps

module pkt_framer
    import pkt_gen_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  cmd_start,
    input  logic [DEST_W-1:0]     cmd_dest,
    input  logic [PRIO_W-1:0]     cmd_prio,
    input  logic [LEN_W-1:0]      cmd_len,

    output logic                  push_valid,
    output logic [DATA_WIDTH-1:0] push_data,
    output logic                  push_sop,
    output logic                  push_eop,
    input  logic                  push_ready,

    output logic                  pkt_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t            state;
    logic [DEST_W-1:0] dest_q;
    logic [PRIO_W-1:0] prio_q;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  word_cnt;
    logic              xfer;
    logic              last_word;

    assign xfer      = push_valid && push_ready;
    assign last_word = (word_cnt == len_q - 1'b1);

    // command latched on start, held for the whole packet
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_start) begin
            dest_q <= cmd_dest;
            prio_q <= cmd_prio;
            len_q  <= cmd_len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (xfer) begin
                        state    <= ST_PAYLOAD;
                        word_cnt <= '0;
                    end
                end
                ST_PAYLOAD: begin
                    if (xfer) begin
                        if (last_word) begin
                            state <= ST_IDLE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ****************************************
    // push side, held while stalled
    // ****************************************
    assign push_valid = (state != ST_IDLE);
    assign push_sop   = (state == ST_HEADER);
    assign push_eop   = (state == ST_PAYLOAD) && last_word;

    always_comb begin
        if (state == ST_HEADER) begin
            push_data = pack_header(dest_q, prio_q, len_q);
        end else begin
            push_data = {{(DATA_WIDTH-LEN_W){1'b0}}, word_cnt};
        end
    end

    assign pkt_done = xfer && push_eop;  // last word accepted

endmodule

//--- hw/pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo
    import pkt_gen_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  push_valid,
    output logic                  push_ready,
    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  push_sop,
    input  logic                  push_eop,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_sop,
    output logic                  out_eop
);

    localparam int AW     = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = DATA_WIDTH + 2;   // data plus sop/eop

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        count;
    logic               do_push;
    logic               do_pop;

    assign push_ready = (count != (AW+1)'(FIFO_DEPTH));
    assign out_valid  = (count != '0);

    assign do_push = push_valid && push_ready;
    assign do_pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_eop, push_sop, push_data};
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // oldest entry, stable until popped
    assign {out_eop, out_sop, out_data} = mem[rd_ptr];

endmodule

//--- hw/pkt_gen_top.sv
`timescale 1ns/1ps

module pkt_gen_top
    import pkt_gen_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_sop,
    output logic                  out_eop
);

    logic                  cmd_start;
    logic [DEST_W-1:0]     cmd_dest;
    logic [PRIO_W-1:0]     cmd_prio;
    logic [LEN_W-1:0]      cmd_len;
    logic                  pkt_done;
    logic                  push_valid;
    logic                  push_ready;
    logic [DATA_WIDTH-1:0] push_data;
    logic                  push_sop;
    logic                  push_eop;

    // ****************************************
    // register block, framer, output fifo
    // ****************************************
    pkt_gen_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .cmd_start (cmd_start),
        .cmd_dest  (cmd_dest),
        .cmd_prio  (cmd_prio),
        .cmd_len   (cmd_len),
        .pkt_done  (pkt_done)
    );

    pkt_framer i_framer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd_dest   (cmd_dest),
        .cmd_prio   (cmd_prio),
        .cmd_len    (cmd_len),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_sop   (push_sop),
        .push_eop   (push_eop),
        .push_ready (push_ready),
        .pkt_done   (pkt_done)
    );

    pkt_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_data  (push_data),
        .push_sop   (push_sop),
        .push_eop   (push_eop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_sop    (out_sop),
        .out_eop    (out_eop)
    );

endmodule

//--- bench/tb_pkt_gen.sv
`timescale 1ns/1ps

module tb_pkt_gen
    import pkt_gen_pkg::*;
;

    localparam int FIFO_DEPTH = 4;              // shallow, so back-pressure reaches the framer

    logic                  clk;
    logic                  rst_n;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  out_valid;
    logic                  out_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_sop;
    logic                  out_eop;

    integer seed = 87691;
    int     ready_mode;
    int     errors;
    int     tests_ok;
    int     tests_bad;
    int     exp_count;
    int     budget_ns;

    // expected beats as {eop, sop, data}
    logic [DATA_WIDTH+1:0] exp_q[$];

    int          stim_dest[$];
    int          stim_prio[$];
    int          stim_len[$];
    int          stim_mode[$];
    logic [31:0] stim_hdr[$];

    pkt_gen_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_sop   (out_sop),
        .out_eop   (out_eop)
    );

    always #5 clk = ~clk;

    // ****************************************
    // helpers
    // ****************************************
    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected 0x%h actual 0x%h", $time, name, exp, act);
            errors++;
        end
    endtask

    // len 7:0, prio 10:8, dest 14:11
    function automatic logic [31:0] header_word(input int dest, input int prio, input int len);
        logic [31:0] w;
        w = 32'(len & 8'hff);
        w = w | (32'(prio & 7) << 8);
        w = w | (32'(dest & 15) << 11);
        return w;
    endfunction

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge clk); while (!awready);
        compare_value("wready", 32'h1, 32'(wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk); while (!bvalid);
        compare_value("bresp", 32'h0, 32'(bresp));   // always okay
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        compare_value("rresp", 32'h0, 32'(rresp));
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic load_stim();
        int    fd;
        int    rc;
        int    d;
        int    p;
        int    l;
        int    m;
        logic [31:0] h;
        string line;
        fd = $fopen("bench/pkt_gen_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/pkt_gen_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc != 0 && line.len() > 0 && line[0] != "#") begin
                    rc = $sscanf(line, "%d %d %d %d %h", d, p, l, m, h);
                    if (rc == 5) begin
                        stim_dest.push_back(d);
                        stim_prio.push_back(p);
                        stim_len.push_back(l);
                        stim_mode.push_back(m);
                        stim_hdr.push_back(h);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_packet(input int idx);
        int          dest;
        int          prio;
        int          len;
        int          mode;
        int          err_before;
        logic [31:0] rd;
        dest = stim_dest[idx];
        prio = stim_prio[idx];
        len  = stim_len[idx];
        mode = stim_mode[idx];
        err_before = errors;
        compare_value("stim header", header_word(dest, prio, len), stim_hdr[idx]);
        ready_mode = mode;
        if (len != 0) begin
            exp_q.push_back({1'b0, 1'b1, stim_hdr[idx]});
            for (int i = 0; i < len; i++) begin
                exp_q.push_back({i == len - 1, 1'b0, 32'(i)});
            end
            exp_count++;
        end
        axi_write(REG_DEST, 32'(dest));
        axi_write(REG_PRIO, 32'(prio));
        axi_write(REG_LEN, 32'(len));
        axi_write(REG_CTRL, 32'h1);
        if (mode == 2) begin
            axi_read(REG_STATUS, rd);
            compare_value("REG_STATUS", 32'h1, rd);   // packet still in flight
            axi_write(REG_CTRL, 32'h1);          // lands while busy
        end
        if (len != 0) begin
            while (exp_q.size() != 0) @(negedge clk);
        end else begin
            repeat (20) @(negedge clk);          // nothing should come out
        end
        axi_read(REG_DEST, rd);
        compare_value("REG_DEST", 32'(dest), rd);
        axi_read(REG_PRIO, rd);
        compare_value("REG_PRIO", 32'(prio), rd);
        axi_read(REG_LEN, rd);
        compare_value("REG_LEN", 32'(len), rd);
        axi_read(REG_STATUS, rd);
        compare_value("REG_STATUS", 32'h0, rd);
        axi_read(REG_COUNT, rd);
        compare_value("REG_COUNT", 32'(exp_count & 16'hffff), rd);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d: dest %0d prio %0d len %0d mode %0d ok", idx + 1, dest, prio, len,
                     mode);
        end else begin
            tests_bad++;
            $display("test %0d: dest %0d prio %0d len %0d mode %0d, %0d errors", idx + 1, dest,
                     prio, len, mode, errors - err_before);
        end
    endtask

    // ****************************************
    // output stream
    // ****************************************
    always @(negedge clk) begin
        if (ready_mode == 1) begin
            out_ready <= ($random(seed) % 4) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        logic [DATA_WIDTH+1:0] beat;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output beat 0x%h at %0t ns", out_data, $time);
                errors++;
            end else begin
                beat = exp_q.pop_front();
                compare_value("out_data", beat[DATA_WIDTH-1:0], out_data);
                compare_value("out_sop", 32'(beat[DATA_WIDTH]), 32'(out_sop));
                compare_value("out_eop", 32'(beat[DATA_WIDTH+1]), 32'(out_eop));
            end
        end
    end

    // watchdog, budget comes from the stimulus lengths
    initial begin
        wait (budget_ns != 0);
        #(budget_ns);
        $display("timeout after %0d ns, the output stream or the register bus stalled", budget_ns);
        $display("Test failed");
        $finish;
    end

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        logic [31:0] rd;
        int          err_before;
        clk        = 1'b0;
        rst_n      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        out_ready  = 1'b0;
        ready_mode = 0;
        errors     = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        exp_count  = 0;
        budget_ns  = 0;

        load_stim();
        budget_ns = 2000;
        foreach (stim_len[i]) begin
            budget_ns += (stim_len[i] + 1) * 4 * 10;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err_before = errors;
        compare_value("out_valid", 32'h0, 32'(out_valid));
        axi_read(REG_STATUS, rd);
        compare_value("REG_STATUS", 32'h0, rd);
        axi_read(REG_COUNT, rd);
        compare_value("REG_COUNT", 32'h0, rd);
        if (errors == err_before) begin
            tests_ok++;
            $display("test 0: reset values ok");
        end else begin
            tests_bad++;
            $display("test 0: reset values, %0d errors", errors - err_before);
        end

        foreach (stim_len[i]) begin
            run_packet(i);
        end

        $display("tests ok %0d, tests with errors %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/pkt_gen_stim.txt
# columns: dest prio len mode header_hex
# mode 0 ready held high, 1 random out_ready, 2 second start while busy
0 0 16 0 00000010
5 3 20 0 00002B14
15 7 32 0 00007F20
1 1 1 0 00000901
2 4 2 0 00001402
9 2 0 0 00004A00
3 5 24 1 00001D18
12 6 40 1 00006628
7 0 64 1 00003840
4 2 18 2 00002212
10 1 48 0 00005130
6 7 255 1 000037FF
8 3 17 1 00004311
11 4 30 2 00005C1E
13 5 100 0 00006D64
14 6 20 1 00007614
0 7 33 1 00000721
15 0 0 0 00007800
1 6 50 1 00000E32
2 2 25 0 00001219
3 3 128 1 00001B80
4 4 19 2 00002413
5 5 60 1 00002D3C
6 1 21 0 00003115
7 7 36 1 00003F24
8 0 22 0 00004016
9 6 45 1 00004E2D
10 3 16 2 00005310
11 2 80 1 00005A50
12 1 27 0 0000611B
13 4 200 1 00006CC8
14 5 23 1 00007517
15 6 31 0 00007E1F
0 3 70 1 00000346
5 0 16 1 00002810
9 7 42 0 00004F2A
3 1 255 0 000019FF
2 4 20 2 00001414

//--- src.f
hw/pkt_gen_pkg.sv
hw/pkt_gen_regs.sv
hw/pkt_framer.sv
hw/pkt_fifo.sv
hw/pkt_gen_top.sv
bench/tb_pkt_gen.sv

//--- Bender.yml
package:
  name: pkt_gen

sources:
  - files:
      - hw/pkt_gen_pkg.sv
      - hw/pkt_gen_regs.sv
      - hw/pkt_framer.sv
      - hw/pkt_fifo.sv
      - hw/pkt_gen_top.sv
  - target: test
    files:
      - bench/tb_pkt_gen.sv
